// ==== diff_trigger_settings.svh ====
/*
  compile-time settings shared by the differentiator trigger design
  include this wherever sample width, lane count or holdoff length is needed
*/
`ifndef DIFF_TRIGGER_SETTINGS_SVH
`define DIFF_TRIGGER_SETTINGS_SVH

// width of one signed sample in bits
`define SAMPLE_WIDTH 16

// samples carried per beat, lowest index is oldest in time
`define PARALLEL_SAMPLES 2

// output beats forced untriggered after a trigger fires
`define HOLDOFF_BEATS 4

`endif

// ==== diff_trigger_pkg.sv ====
/*
  stream types for the differentiator trigger
  modules refer to these by scoped name, widths come from the settings header
*/
`default_nettype none
`include "diff_trigger_settings.svh"

package diff_trigger_pkg;

  // one signed sample, two's complement
  typedef logic signed [`SAMPLE_WIDTH-1:0] sample_t;

  // one stream beat
  typedef struct packed {
    sample_t [`PARALLEL_SAMPLES-1:0] samples; // samples[0] is earliest
    logic                            last;    // end of packet marker
  } sample_beat_t;

  // beat leaving the trigger stage
  typedef struct packed {
    sample_beat_t beat; // differences and last, passed through untouched
    logic         trig; // set on the beat that fired the trigger
  } trigger_beat_t;

  // trigger FSM state
  typedef enum logic {
    trig_armed   = 1'b0, // waiting for a difference above threshold
    trig_holdoff = 1'b1  // counting out suppressed beats
  } trigger_state_t;

endpackage

`default_nettype wire

// ==== stream_skid_buffer.sv ====
/*
  two-entry skid stage on the valid/ready stream
  registers the beat and in_ready so no combinational path crosses the stage
*/
`timescale 1ns/1ps
`default_nettype none
`include "diff_trigger_settings.svh"

module stream_skid_buffer (
  input  logic                           clk,
  input  logic                           reset,
  input  diff_trigger_pkg::sample_beat_t in_beat,
  input  logic                           in_valid,
  output logic                           in_ready,
  output diff_trigger_pkg::sample_beat_t skid_beat,
  output logic                           skid_valid,
  input  logic                           skid_ready
);

  diff_trigger_pkg::sample_beat_t main_beat;  // beat presented downstream
  diff_trigger_pkg::sample_beat_t spare_beat; // catches a beat while main is stuck
  logic main_valid;
  logic spare_valid;
  logic main_valid_next;
  logic spare_valid_next;
  logic in_fire;   // upstream transfer this cycle
  logic main_free; // main entry can take a new beat

  assign in_fire   = in_valid && in_ready;
  assign main_free = !main_valid || skid_ready; // empty or being accepted

  // occupancy of the two entries
  always_comb begin
    main_valid_next  = main_valid;
    spare_valid_next = spare_valid;
    if (main_free) begin
      if (spare_valid) begin
        main_valid_next  = 1'b1;    // spare moves up first
        spare_valid_next = in_fire; // new beat drops into spare behind it
      end else begin
        main_valid_next  = in_fire;
      end
    end else if (in_fire) begin
      spare_valid_next = 1'b1;      // downstream stalled, park the arrival
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      main_valid  <= 1'b0;
      spare_valid <= 1'b0;
      in_ready    <= 1'b1;
    end else begin
      main_valid  <= main_valid_next;
      spare_valid <= spare_valid_next;
      in_ready    <= !(main_valid_next && spare_valid_next); // low only when full
    end
  end

  // payload movement mirrors the occupancy logic above
  always_ff @(posedge clk) begin
    if (main_free) begin
      if (spare_valid) begin
        main_beat <= spare_beat;
        if (in_fire) begin
          spare_beat <= in_beat;
        end
      end else if (in_fire) begin
        main_beat <= in_beat;
      end
    end else if (in_fire) begin
      spare_beat <= in_beat;
    end
  end

  assign skid_beat  = main_beat;
  assign skid_valid = main_valid;

endmodule

`default_nettype wire

// ==== axis_differentiator.sv ====
/*
  first-order finite difference across the parallel samples of each beat
  four register stages, the whole pipe advances together on the stream handshake
*/
`timescale 1ns/1ps
`default_nettype none
`include "diff_trigger_settings.svh"

module axis_differentiator (
  input  logic                           clk,
  input  logic                           reset,
  input  diff_trigger_pkg::sample_beat_t skid_beat,
  input  logic                           skid_valid,
  output logic                           skid_ready,
  output diff_trigger_pkg::sample_beat_t diff_beat,
  output logic                           diff_valid,
  input  logic                           diff_ready
);

  diff_trigger_pkg::sample_t in_reg [`PARALLEL_SAMPLES]; // stage 0, accepted samples
  diff_trigger_pkg::sample_t prev_sample;                // last sample of the beat before
  diff_trigger_pkg::sample_t pred [`PARALLEL_SAMPLES];   // predecessor of each lane
  logic signed [`SAMPLE_WIDTH:0] diff [`PARALLEL_SAMPLES]; // stage 1, full width
  diff_trigger_pkg::sample_t trunc [`PARALLEL_SAMPLES];  // stage 2, halved
  diff_trigger_pkg::sample_t out_reg [`PARALLEL_SAMPLES]; // stage 3
  logic [3:0] valid_d; // valid per stage, bit 3 is the output
  logic [3:0] last_d;  // last flag riding with valid
  logic advance;       // every stage moves this cycle
  logic in_ok;         // a beat is accepted this cycle

  assign advance    = !valid_d[3] || diff_ready;
  assign skid_ready = advance;
  assign in_ok      = skid_valid && advance;

  // lane 0 looks back into the previous beat, the rest look one lane down
  always_comb begin
    pred[0] = prev_sample;
    for (int i = 1; i < `PARALLEL_SAMPLES; i++) begin
      pred[i] = in_reg[i-1];
    end
  end

  // input capture and control shift registers
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_d     <= '0;
      last_d      <= '0;
      prev_sample <= '0;
      for (int i = 0; i < `PARALLEL_SAMPLES; i++) begin
        in_reg[i] <= '0; // first beat after reset differences against zero
      end
    end else if (advance) begin
      valid_d <= {valid_d[2:0], in_ok};
      last_d  <= {last_d[2:0], skid_beat.last && in_ok};
      if (in_ok) begin
        for (int i = 0; i < `PARALLEL_SAMPLES; i++) begin
          in_reg[i] <= skid_beat.samples[i];
        end
        prev_sample <= in_reg[`PARALLEL_SAMPLES-1]; // held beat becomes history
      end
    end
  end

  // subtract, halve, output
  always_ff @(posedge clk) begin
    if (advance) begin
      for (int i = 0; i < `PARALLEL_SAMPLES; i++) begin
        diff[i]    <= in_reg[i] - pred[i]; // sign extended to 17 bits, cannot wrap
        trunc[i]   <= diff[i][`SAMPLE_WIDTH -: `SAMPLE_WIDTH]; // drop lsb
        out_reg[i] <= trunc[i];
      end
    end
  end

  always_comb begin
    for (int i = 0; i < `PARALLEL_SAMPLES; i++) begin
      diff_beat.samples[i] = out_reg[i];
    end
    diff_beat.last = last_d[3];
  end

  assign diff_valid = valid_d[3];

endmodule

`default_nettype wire

// ==== threshold_trigger.sv ====
/*
  tags beats whose difference magnitude exceeds a runtime threshold
  after a trigger the next HOLDOFF_BEATS beats pass untagged, then it rearms
*/
`timescale 1ns/1ps
`default_nettype none
`include "diff_trigger_settings.svh"

module threshold_trigger (
  input  logic                            clk,
  input  logic                            reset,
  input  diff_trigger_pkg::sample_beat_t  diff_beat,
  input  logic                            diff_valid,
  output logic                            diff_ready,
  input  diff_trigger_pkg::sample_t       threshold,
  output diff_trigger_pkg::trigger_beat_t out_beat,
  output logic                            out_valid,
  input  logic                            out_ready
);

  localparam int CNT_W = $clog2(`HOLDOFF_BEATS + 1); // holds 0..HOLDOFF_BEATS

  diff_trigger_pkg::trigger_state_t state;
  diff_trigger_pkg::trigger_state_t state_next;
  logic [CNT_W-1:0] holdoff_cnt;      // beats still to suppress
  logic [CNT_W-1:0] holdoff_cnt_next;
  logic advance;   // output register free or being drained
  logic in_ok;     // beat taken from the differentiator
  logic exceed;    // some lane above threshold
  logic trig_next; // tag for the beat being taken

  assign advance    = !out_valid || out_ready;
  assign diff_ready = advance;
  assign in_ok      = diff_valid && advance;

  // magnitude compare, one extra bit so that -32768 has a positive magnitude
  always_comb begin
    diff_trigger_pkg::sample_t s;
    logic signed [`SAMPLE_WIDTH:0] mag;
    s      = '0;
    mag    = '0;
    exceed = 1'b0;
    for (int i = 0; i < `PARALLEL_SAMPLES; i++) begin
      s   = diff_beat.samples[i];
      mag = s; // sign extends
      if (mag < 0) begin
        mag = -mag;
      end
      if (mag > threshold) begin
        exceed = 1'b1;
      end
    end
  end

  // trigger FSM, only moves on an accepted beat
  always_comb begin
    state_next       = state;
    holdoff_cnt_next = holdoff_cnt;
    trig_next        = 1'b0;
    if (in_ok) begin
      case (state)
        diff_trigger_pkg::trig_armed: begin
          if (exceed) begin
            trig_next        = 1'b1;
            state_next       = diff_trigger_pkg::trig_holdoff;
            holdoff_cnt_next = CNT_W'(`HOLDOFF_BEATS);
          end
        end
        diff_trigger_pkg::trig_holdoff: begin
          holdoff_cnt_next = holdoff_cnt - 1'b1; // this beat is suppressed
          if (holdoff_cnt == CNT_W'(1)) begin
            state_next = diff_trigger_pkg::trig_armed; // last suppressed beat
          end
        end
        default: state_next = diff_trigger_pkg::trig_armed;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= diff_trigger_pkg::trig_armed;
      holdoff_cnt <= '0;
      out_valid   <= 1'b0;
    end else begin
      state       <= state_next;
      holdoff_cnt <= holdoff_cnt_next;
      if (advance) begin
        out_valid <= diff_valid;
      end
    end
  end

  // output payload, samples and last unchanged
  always_ff @(posedge clk) begin
    if (in_ok) begin
      out_beat.beat <= diff_beat;
      out_beat.trig <= trig_next;
    end
  end

endmodule

`default_nettype wire

// ==== diff_trigger_top.sv ====
/*
  trigger front end: skid stage, differentiator, threshold trigger in series
  six cycles of latency from input transfer to output valid with no stall
*/
`timescale 1ns/1ps
`default_nettype none
`include "diff_trigger_settings.svh"

module diff_trigger_top (
  input  logic                            clk,
  input  logic                            reset,
  input  diff_trigger_pkg::sample_beat_t  in_beat,
  input  logic                            in_valid,
  output logic                            in_ready,
  input  diff_trigger_pkg::sample_t       threshold,
  output diff_trigger_pkg::trigger_beat_t out_beat,
  output logic                            out_valid,
  input  logic                            out_ready
);

  diff_trigger_pkg::sample_beat_t skid_beat; // skid -> differentiator
  logic                           skid_valid;
  logic                           skid_ready;
  diff_trigger_pkg::sample_beat_t diff_beat; // differentiator -> trigger
  logic                           diff_valid;
  logic                           diff_ready;

  stream_skid_buffer stream_skid_buffer_i (
    .clk        (clk),
    .reset      (reset),
    .in_beat    (in_beat),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .skid_beat  (skid_beat),
    .skid_valid (skid_valid),
    .skid_ready (skid_ready)
  );

  axis_differentiator axis_differentiator_i (
    .clk        (clk),
    .reset      (reset),
    .skid_beat  (skid_beat),
    .skid_valid (skid_valid),
    .skid_ready (skid_ready),
    .diff_beat  (diff_beat),
    .diff_valid (diff_valid),
    .diff_ready (diff_ready)
  );

  threshold_trigger threshold_trigger_i (
    .clk        (clk),
    .reset      (reset),
    .diff_beat  (diff_beat),
    .diff_valid (diff_valid),
    .diff_ready (diff_ready),
    .threshold  (threshold),  // held stable by the outside
    .out_beat   (out_beat),
    .out_valid  (out_valid),
    .out_ready  (out_ready)
  );

endmodule

`default_nettype wire

// ==== diff_trigger_properties.sv ====
/*
  concurrent checks on the top-level stream handshakes of the trigger front end
  attached to every diff_trigger_top by the bind at the bottom
*/
`timescale 1ns/1ps
`default_nettype none

module diff_trigger_properties (
  input logic                            clk,
  input logic                            reset,
  input logic                            in_ready,
  input diff_trigger_pkg::trigger_beat_t out_beat,
  input logic                            out_valid,
  input logic                            out_ready
);

  // pipeline leaves reset empty
  out_valid_low_after_reset: assert property (@(posedge clk) reset |=> !out_valid)
    else $error("out_valid high in the cycle after reset");

  // skid entries both free after reset
  in_ready_high_after_reset: assert property (@(posedge clk) reset |=> in_ready)
    else $error("in_ready low in the cycle after reset");

  // stalled beat is held until taken
  out_beat_held_on_stall: assert property (@(posedge clk) disable iff (reset)
    out_valid && !out_ready |=> out_valid && $stable(out_beat))
    else $error("output beat changed or dropped while stalled");

endmodule

bind diff_trigger_top diff_trigger_properties diff_trigger_properties_i (
  .clk       (clk),
  .reset     (reset),
  .in_ready  (in_ready),
  .out_beat  (out_beat),
  .out_valid (out_valid),
  .out_ready (out_ready)
);

`default_nettype wire

// ==== diff_trigger_tb.sv ====
/*
  vector-driven testbench for the trigger front end
  beats from diff_vectors.txt go in with random gaps and back-pressure and are checked in order
*/
`timescale 1ns/1ps
`default_nettype none
`include "diff_trigger_settings.svh"

module diff_trigger_tb;

  localparam int NUM_VECTORS    = 26;
  localparam int FIELDS         = 7;  // x0 x1 last threshold e0 e1 trig
  localparam int RESET_CYCLES   = 10;
  localparam int TIMEOUT_CYCLES = 8 * NUM_VECTORS + RESET_CYCLES;
  localparam logic [15:0] LFSR_SEED = 16'd62;

  logic                            clk;
  logic                            reset;
  diff_trigger_pkg::sample_beat_t  in_beat;
  logic                            in_valid;
  logic                            in_ready;
  diff_trigger_pkg::sample_t       threshold;
  diff_trigger_pkg::trigger_beat_t out_beat;
  logic                            out_valid;
  logic                            out_ready;

  logic [`SAMPLE_WIDTH-1:0] vec_mem [0:NUM_VECTORS*FIELDS-1]; // FIELDS words per beat in a row
  diff_trigger_pkg::trigger_beat_t expected_q [$];            // scoreboard with oldest beat first
  logic [15:0] lfsr;
  int cycle_cnt;
  int sent;     // beats accepted by the DUT
  int received; // beats taken from the DUT

  diff_trigger_top diff_trigger_top_i (
    .clk       (clk),
    .reset     (reset),
    .in_beat   (in_beat),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .threshold (threshold),
    .out_beat  (out_beat),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  always #5 clk = ~clk; // 10 ns period

  // feedback from x^16 + x^14 + x^13 + x^11 + 1 enters at bit 0
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  // one step per bit handed out
  function automatic logic random_bit();
    lfsr = lfsr_step(lfsr);
    return lfsr[0];
  endfunction

  function automatic logic [`SAMPLE_WIDTH-1:0] vector_field(input int v, input int f);
    return vec_mem[v*FIELDS + f];
  endfunction

  function automatic diff_trigger_pkg::sample_beat_t input_beat(input int v);
    diff_trigger_pkg::sample_beat_t b;
    logic [`SAMPLE_WIDTH-1:0] w;
    w = vector_field(v, 2);
    b.samples[0] = vector_field(v, 0);
    b.samples[1] = vector_field(v, 1);
    b.last       = w[0];
    return b;
  endfunction

  function automatic diff_trigger_pkg::trigger_beat_t expected_beat(input int v);
    diff_trigger_pkg::trigger_beat_t b;
    logic [`SAMPLE_WIDTH-1:0] w_last;
    logic [`SAMPLE_WIDTH-1:0] w_trig;
    w_last = vector_field(v, 2);
    w_trig = vector_field(v, 6);
    b.beat.samples[0] = vector_field(v, 4);
    b.beat.samples[1] = vector_field(v, 5);
    b.beat.last       = w_last[0];
    b.trig            = w_trig[0];
    return b;
  endfunction

  task automatic check_value(input string what, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("[ERROR] %0t: %s: got %h, expected %h", $time, what, actual, expected);
      $display("RESULT: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  // one output transfer against the oldest scoreboard entry
  task automatic check_output();
    diff_trigger_pkg::trigger_beat_t exp_beat;
    check_value("output beat with an empty scoreboard", expected_q.size() > 0, 1);
    exp_beat = expected_q.pop_front();
    check_value($sformatf("beat %0d sample 0", received),
                out_beat.beat.samples[0], exp_beat.beat.samples[0]);
    check_value($sformatf("beat %0d sample 1", received),
                out_beat.beat.samples[1], exp_beat.beat.samples[1]);
    check_value($sformatf("beat %0d last", received), out_beat.beat.last, exp_beat.beat.last);
    check_value($sformatf("beat %0d trig", received), out_beat.trig, exp_beat.trig);
  endtask

  // hang guard
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: only %0d of %0d beats came out within %0d cycles",
               received, NUM_VECTORS, TIMEOUT_CYCLES);
      $display("RESULT: FAIL");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  initial begin
    logic gap;
    logic taken; // beat accepted at the last edge
    clk       = 1'b0;
    reset     = 1'b1;
    in_beat   = '0;
    in_valid  = 1'b0;
    out_ready = 1'b0;
    threshold = '0;
    lfsr      = LFSR_SEED;
    cycle_cnt = 0;
    sent      = 0;
    received  = 0;
    taken     = 1'b0;
    $readmemh("diff_vectors.txt", vec_mem);
    check_value("vector file loaded", $isunknown(vec_mem[0]), 0);
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset     = 1'b0;
    threshold = vector_field(0, 3); // same threshold on every line
    while (received < NUM_VECTORS) begin
      if (taken) begin
        in_valid = 1'b0;
        taken    = 1'b0;
      end
      if (!in_valid && sent < NUM_VECTORS) begin
        gap = random_bit();
        gap = gap & random_bit(); // about one slot in four left idle
        if (!gap) begin
          in_beat  = input_beat(sent);
          in_valid = 1'b1; // held until accepted
        end
      end
      out_ready = random_bit();
      @(negedge clk); // handshakes are settled mid cycle and transfer at the next edge
      if (in_valid && in_ready) begin
        expected_q.push_back(expected_beat(sent));
        sent++;
        taken = 1'b1;
      end
      if (out_valid && out_ready) begin
        check_output();
        received++;
      end
      @(posedge clk);
      #1;
    end
    in_valid  = 1'b0;
    out_ready = 1'b1;
    repeat (8) begin
      @(negedge clk);
      check_value("out_valid after the last beat", out_valid, 0); // no duplicates
    end
    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+.
diff_trigger_pkg.sv
stream_skid_buffer.sv
axis_differentiator.sv
threshold_trigger.sv
diff_trigger_top.sv
diff_trigger_properties.sv
diff_trigger_tb.sv

// ==== Bender.yml ====
package:
  name: diff_trigger

sources:
  - include_dirs:
      - .
    files:
      - diff_trigger_pkg.sv
      - stream_skid_buffer.sv
      - axis_differentiator.sv
      - threshold_trigger.sv
      - diff_trigger_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - diff_trigger_properties.sv
      - diff_trigger_tb.sv

// ==== diff_vectors.txt ====
// columns: in sample 0, in sample 1, last, threshold, expected diff 0, expected diff 1, trig
// all hex, one beat per line, expected diff is (x[i] - x[i-1]) >> 1 with floor rounding
FFF9 000D 0 0100 FFFC 000A 0
0021 0035 0 0100 000A 000A 0
0049 005D 1 0100 000A 000A 0
0071 0085 0 0100 000A 000A 0
0085 0285 0 0100 0000 0100 0
0285 0487 0 0100 0000 0101 1
0689 0285 1 0100 0101 FDFE 0
8000 7FFF 0 0100 BEBD 7FFF 0
8000 7FFF 0 0100 8000 7FFF 0
8000 8000 0 0100 8000 0000 0
7FFF 7FFF 1 0100 7FFF 0000 1
7FF5 7FEB 0 0100 FFFB FFFB 0
7FE1 7FD7 0 0100 FFFB FFFB 0
7FCD 7FC3 0 0100 FFFB FFFB 0
7FC2 7FC2 1 0100 FFFF 0000 0
7FC3 7FC2 0 0100 0000 FFFF 0
7DC0 7DC0 0 0100 FEFF 0000 1
0000 0000 0 0100 C120 0000 0
0000 0064 0 0100 0000 0032 0
00C8 012C 0 0100 0032 0032 0
FF38 FE0C 1 0100 FF06 FF6A 0
FC18 FC18 0 0100 FF06 0000 0
FA23 FA23 0 0100 FF05 0000 0
F81F F81F 0 0100 FEFE 0000 1
0001 FFFF 0 0100 03F1 FFFF 0
0000 0000 1 0100 0000 0000 0
